/* design/mem_pkg.sv */
package mem_pkg;

    localparam int ADDR_W      = 16;                    // processor address width
    localparam int DATA_W      = 16;                    // word width
    localparam int CACHE_IDX_W = 4;                     // low address bits pick the line
    localparam int TAG_W       = ADDR_W - CACHE_IDX_W;  // remaining upper bits
    localparam int CACHE_DEPTH = 1 << CACHE_IDX_W;      // 16 one-word lines
    localparam int MEM_IDX_W   = 8;                     // memory word index, upper bits alias
    localparam int MEM_DEPTH   = 1 << MEM_IDX_W;        // 256 words
    localparam int MEM_LATENCY = 4;                     // accept edge to valid pulse

    localparam logic [DATA_W-1:0] MEM_INIT_PATTERN = 16'h5a5a;  // word i starts as i ^ pattern

    // cache controller states
    typedef enum logic [1:0] {
        ST_IDLE,                                        // hit or waiting for access
        ST_FILL,                                        // read miss, line fill pending
        ST_WRITE                                        // write-through pending
    } cache_state_e;

    // who holds the memory port
    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_I,
        OWN_D
    } owner_e;

endpackage

/* design/icache.sv */
`timescale 1ns/1ns

module icache (
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  logic [mem_pkg::ADDR_W-1:0] i_addr,          // fetch address (pc)
    input  logic [mem_pkg::DATA_W-1:0] i_mem_data,      // shared memory read word
    input  logic                       i_mem_data_vld,  // valid pulse, routed only when granted
    output logic                       o_read_req,      // fill request to arbiter
    output logic                       o_fsm_busy,      // stall the fetch stage
    output logic [mem_pkg::ADDR_W-1:0] o_miss_addr,     // address of the line to fill
    output logic [mem_pkg::DATA_W-1:0] o_data_out       // instruction word
);
    import mem_pkg::*;

    cache_state_e              state_q;                 // fill fsm
    logic [CACHE_DEPTH-1:0]    valid_q;                 // per-line valid bits
    logic [TAG_W-1:0]          tag_q  [CACHE_DEPTH];    // tag array
    logic [DATA_W-1:0]         data_q [CACHE_DEPTH];    // data array
    logic [CACHE_IDX_W-1:0]    idx;
    logic [TAG_W-1:0]          tag;
    logic                      hit;
    logic                      fill_done;

    assign idx       = i_addr[CACHE_IDX_W-1:0];         // direct mapped index
    assign tag       = i_addr[ADDR_W-1:CACHE_IDX_W];
    assign hit       = valid_q[idx] && (tag_q[idx] == tag);
    assign fill_done = (state_q == ST_FILL) && i_mem_data_vld;

    // request goes out in the miss cycle, held through the fill
    assign o_read_req  = ((state_q == ST_IDLE) && !hit) || (state_q == ST_FILL);
    assign o_fsm_busy  = !hit || (state_q == ST_FILL);  // falls once the line is written
    assign o_miss_addr = i_addr;                         // one-word lines, no offset
    assign o_data_out  = data_q[idx];                    // combinational hit path

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q <= ST_IDLE;
            valid_q <= '0;                               // cache starts empty
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (!hit) begin
                        state_q <= ST_FILL;              // wait for the memory word
                    end
                end
                ST_FILL: begin
                    if (i_mem_data_vld) begin
                        state_q      <= ST_IDLE;
                        valid_q[idx] <= 1'b1;            // line now usable
                    end
                end
                default: state_q <= ST_IDLE;             // icache never writes
            endcase
        end
    end

    // line payload
    always_ff @(posedge clk) begin
        if (fill_done) begin
            tag_q[idx]  <= tag;
            data_q[idx] <= i_mem_data;
        end
    end

endmodule

/* design/dcache.sv */
`timescale 1ns/1ns

module dcache (
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  logic [mem_pkg::ADDR_W-1:0] i_addr,          // data address
    input  logic [mem_pkg::DATA_W-1:0] i_wdata,         // store data
    input  logic                       i_wrt_en,        // store strobe
    input  logic                       i_mem_en,        // access enable
    input  logic [mem_pkg::DATA_W-1:0] i_mem_data,      // shared memory read word
    input  logic                       i_mem_data_vld,  // valid pulse for this cache
    output logic                       o_read_req,      // line fill request
    output logic                       o_wrt_mem,       // write-through request
    output logic                       o_fsm_busy,      // stall the memory stage
    output logic [mem_pkg::ADDR_W-1:0] o_cache_addr,    // address toward memory
    output logic [mem_pkg::DATA_W-1:0] o_data_out       // load result
);
    import mem_pkg::*;

    cache_state_e              state_q;
    logic [CACHE_DEPTH-1:0]    valid_q;
    logic [TAG_W-1:0]          tag_q  [CACHE_DEPTH];
    logic [DATA_W-1:0]         data_q [CACHE_DEPTH];
    logic [CACHE_IDX_W-1:0]    idx;
    logic [TAG_W-1:0]          tag;
    logic                      hit;
    logic                      rd_miss;                 // load that needs a fill
    logic                      wr_start;                // store seen in idle
    logic                      line_we;                 // array payload write
    logic                      in_idle;

    assign idx      = i_addr[CACHE_IDX_W-1:0];
    assign tag      = i_addr[ADDR_W-1:CACHE_IDX_W];
    assign hit      = valid_q[idx] && (tag_q[idx] == tag);
    assign in_idle  = (state_q == ST_IDLE);
    assign rd_miss  = i_mem_en && !i_wrt_en && !hit;
    assign wr_start = i_mem_en && i_wrt_en;

    // requests raised combinationally in idle so memory can accept at once
    assign o_read_req = (in_idle && rd_miss) || (state_q == ST_FILL);
    assign o_wrt_mem  = (in_idle && wr_start) || (state_q == ST_WRITE);

    always_comb begin
        case (state_q)
            ST_IDLE:  o_fsm_busy = rd_miss || wr_start;
            ST_FILL:  o_fsm_busy = 1'b1;                 // drops when the line hits
            ST_WRITE: o_fsm_busy = !i_mem_data_vld;      // done on the write pulse
            default:  o_fsm_busy = 1'b0;
        endcase
    end

    assign o_cache_addr = i_addr;
    assign o_data_out   = data_q[idx];                   // valid when busy low, load enabled

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q <= ST_IDLE;
            valid_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (wr_start) begin
                        state_q <= ST_WRITE;
                    end else if (rd_miss) begin
                        state_q <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    if (i_mem_data_vld) begin
                        state_q      <= ST_IDLE;
                        valid_q[idx] <= 1'b1;
                    end
                end
                ST_WRITE: begin
                    if (i_mem_data_vld) begin
                        state_q <= ST_IDLE;              // no allocate on write miss
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // fill writes tag and word, a store hit only refreshes the word
    assign line_we = i_mem_data_vld && ((state_q == ST_FILL) || ((state_q == ST_WRITE) && hit));

    always_ff @(posedge clk) begin
        if (line_we) begin
            if (state_q == ST_FILL) begin
                tag_q[idx]  <= tag;
                data_q[idx] <= i_mem_data;
            end else begin
                data_q[idx] <= i_wdata;                  // keep cache coherent with memory
            end
        end
    end

endmodule

/* design/mem_arbiter.sv */
`timescale 1ns/1ns

module mem_arbiter (
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  logic                       i_i_read_req,    // icache fill request
    input  logic [mem_pkg::ADDR_W-1:0] i_i_addr,
    input  logic                       i_d_read_req,    // dcache fill request
    input  logic                       i_d_wrt_mem,     // dcache write-through
    input  logic [mem_pkg::ADDR_W-1:0] i_d_addr,
    input  logic [mem_pkg::DATA_W-1:0] i_d_wdata,
    input  logic                       i_mem_valid,     // memory done pulse
    output logic                       o_mem_en,
    output logic                       o_mem_wr,
    output logic [mem_pkg::ADDR_W-1:0] o_mem_addr,
    output logic [mem_pkg::DATA_W-1:0] o_mem_wdata,
    output logic                       o_i_data_vld,    // pulse back to icache
    output logic                       o_d_data_vld     // pulse back to dcache
);
    import mem_pkg::*;

    owner_e owner_q;                                    // locked until the valid pulse
    owner_e grant;                                      // owner seen by the memory this cycle
    logic   d_req;

    assign d_req = i_d_read_req || i_d_wrt_mem;

    // free port picks a requester now, icache first
    always_comb begin
        grant = owner_q;
        if (owner_q == OWN_NONE) begin
            if (i_i_read_req) begin
                grant = OWN_I;
            end else if (d_req) begin
                grant = OWN_D;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            owner_q <= OWN_NONE;
        end else if (i_mem_valid) begin
            owner_q <= OWN_NONE;                         // transaction finished
        end else begin
            owner_q <= grant;                            // lock on accept
        end
    end

    assign o_mem_en    = (grant == OWN_I) ? i_i_read_req : ((grant == OWN_D) && d_req);
    assign o_mem_wr    = (grant == OWN_D) && i_d_wrt_mem;  // icache only reads
    assign o_mem_addr  = (grant == OWN_D) ? i_d_addr : i_i_addr;
    assign o_mem_wdata = i_d_wdata;                        // only dcache stores
    assign o_i_data_vld = i_mem_valid && (owner_q == OWN_I);
    assign o_d_data_vld = i_mem_valid && (owner_q == OWN_D);

endmodule

/* design/mem_model.sv */
`timescale 1ns/1ns

module mem_model (
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  logic                       i_en,            // request, sampled when idle
    input  logic                       i_wr,            // 1 write, 0 read
    input  logic [mem_pkg::ADDR_W-1:0] i_addr,
    input  logic [mem_pkg::DATA_W-1:0] i_wdata,
    output logic [mem_pkg::DATA_W-1:0] o_rdata,         // read word, good with o_valid
    output logic                       o_valid          // one-cycle completion pulse
);
    import mem_pkg::*;

    logic [DATA_W-1:0]      mem_q [MEM_DEPTH];          // word array
    logic                   busy_q;                     // request in flight
    logic [2:0]             cnt_q;                      // latency counter
    logic                   wr_q;                       // latched request
    logic [MEM_IDX_W-1:0]   idx_q;
    logic [DATA_W-1:0]      wdata_q;

    // power-up contents, index xor pattern
    initial begin
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem_q[i] = DATA_W'(i) ^ MEM_INIT_PATTERN;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            busy_q  <= 1'b0;
            cnt_q   <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= 1'b0;                             // pulse by default
            if (!busy_q) begin
                if (i_en) begin
                    busy_q <= 1'b1;                      // accept edge
                    cnt_q  <= '0;
                end
            end else if (o_valid) begin
                busy_q <= 1'b0;                          // idle after the pulse
            end else if (cnt_q == 3'(MEM_LATENCY - 1)) begin
                o_valid <= 1'b1;
            end else begin
                cnt_q <= cnt_q + 3'd1;
            end
        end
    end

    // request capture and array access
    always_ff @(posedge clk) begin
        if (!busy_q && i_en) begin
            wr_q    <= i_wr;
            idx_q   <= i_addr[MEM_IDX_W-1:0];            // higher bits alias
            wdata_q <= i_wdata;
        end
        if (busy_q && !o_valid && (cnt_q == 3'(MEM_LATENCY - 1))) begin
            if (wr_q) begin
                mem_q[idx_q] <= wdata_q;                 // lands on the pulse
            end else begin
                o_rdata <= mem_q[idx_q];
            end
        end
    end

endmodule

/* design/mem_interface.sv */
`timescale 1ns/1ns

module mem_interface (
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  logic [mem_pkg::ADDR_W-1:0] i_instr_addr,    // pc
    input  logic [mem_pkg::ADDR_W-1:0] i_data_addr,     // load/store address
    input  logic [mem_pkg::DATA_W-1:0] i_data_in,       // store data
    input  logic                       i_d_wrt_en,      // store strobe
    input  logic                       i_d_mem_en,      // data access enable
    output logic                       o_i_fsm_busy,
    output logic                       o_d_fsm_busy,
    output logic [mem_pkg::DATA_W-1:0] o_instr_out,
    output logic [mem_pkg::DATA_W-1:0] o_data_out
);
    import mem_pkg::*;

    logic              mem_en;                          // arbiter to memory
    logic              mem_wr;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata;
    logic [DATA_W-1:0] mem_rdata;                       // shared read word
    logic              mem_valid;

    logic              i_read_req;                      // icache side
    logic              i_data_vld;
    logic [ADDR_W-1:0] i_miss_addr;

    logic              d_read_req;                      // dcache side
    logic              d_wrt_mem;
    logic              d_data_vld;
    logic [ADDR_W-1:0] d_cache_addr;

    icache u_icache (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_addr         (i_instr_addr),
        .i_mem_data     (mem_rdata),
        .i_mem_data_vld (i_data_vld),
        .o_read_req     (i_read_req),
        .o_fsm_busy     (o_i_fsm_busy),
        .o_miss_addr    (i_miss_addr),
        .o_data_out     (o_instr_out)
    );

    dcache u_dcache (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_addr         (i_data_addr),
        .i_wdata        (i_data_in),
        .i_wrt_en       (i_d_wrt_en),
        .i_mem_en       (i_d_mem_en),
        .i_mem_data     (mem_rdata),
        .i_mem_data_vld (d_data_vld),
        .o_read_req     (d_read_req),
        .o_wrt_mem      (d_wrt_mem),
        .o_fsm_busy     (o_d_fsm_busy),
        .o_cache_addr   (d_cache_addr),
        .o_data_out     (o_data_out)
    );

    mem_arbiter u_mem_arbiter (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_i_read_req   (i_read_req),
        .i_i_addr       (i_miss_addr),
        .i_d_read_req   (d_read_req),
        .i_d_wrt_mem    (d_wrt_mem),
        .i_d_addr       (d_cache_addr),
        .i_d_wdata      (i_data_in),                     // store data straight from the port
        .i_mem_valid    (mem_valid),
        .o_mem_en       (mem_en),
        .o_mem_wr       (mem_wr),
        .o_mem_addr     (mem_addr),
        .o_mem_wdata    (mem_wdata),
        .o_i_data_vld   (i_data_vld),
        .o_d_data_vld   (d_data_vld)
    );

    mem_model u_mem_model (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_en           (mem_en),
        .i_wr           (mem_wr),
        .i_addr         (mem_addr),
        .i_wdata        (mem_wdata),
        .o_rdata        (mem_rdata),
        .o_valid        (mem_valid)
    );

endmodule

/* bench/tb_mem_interface.sv */
`timescale 1ns/1ns

module tb_mem_interface;
    import mem_pkg::*;

    localparam int N_OPS   = 80;                          // directed ops plus 60 random
    localparam int TIMEOUT = N_OPS * (2 * MEM_LATENCY + 4) + 200;  // worst op is contended

    logic              clk;
    logic              i_rst_n;
    logic [ADDR_W-1:0] i_instr_addr;
    logic [ADDR_W-1:0] i_data_addr;
    logic [DATA_W-1:0] i_data_in;
    logic              i_d_wrt_en;
    logic              i_d_mem_en;
    logic              o_i_fsm_busy;
    logic              o_d_fsm_busy;
    logic [DATA_W-1:0] o_instr_out;
    logic [DATA_W-1:0] o_data_out;

    logic [DATA_W-1:0] shadow [256];                      // reference copy of memory
    logic [DATA_W-1:0] exp_i;                             // expected fetch word
    logic [DATA_W-1:0] exp_d;                             // expected load word
    logic              chk_instr;                         // fetch in progress
    logic              chk_data;                          // load in progress
    logic [31:0]       lfsr_q;
    string             test_name;
    int                value_errs;
    int                other_errs;
    int                op_cnt;
    int                cycle_cnt;
    int                last_busy;                         // stall cycles of the last op

    mem_interface i_mem_interface (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_instr_addr (i_instr_addr),
        .i_data_addr  (i_data_addr),
        .i_data_in    (i_data_in),
        .i_d_wrt_en   (i_d_wrt_en),
        .i_d_mem_en   (i_d_mem_en),
        .o_i_fsm_busy (o_i_fsm_busy),
        .o_d_fsm_busy (o_d_fsm_busy),
        .o_instr_out  (o_instr_out),
        .o_data_out   (o_data_out)
    );

    always #4 clk = ~clk;                                 // 8 ns period

    // fetch word matches memory whenever the fetch stage is not stalled
    instr_check: assert property (@(posedge clk) disable iff (!i_rst_n)
        (chk_instr && !o_i_fsm_busy) |-> (o_instr_out == exp_i))
    else begin
        value_errs++;
        $display("ERR %s expected %h actual %h", test_name,
                 $sampled(exp_i), $sampled(o_instr_out));
    end

    // load result valid once busy drops with a read enabled
    data_check: assert property (@(posedge clk) disable iff (!i_rst_n)
        (chk_data && i_d_mem_en && !i_d_wrt_en && !o_d_fsm_busy) |-> (o_data_out == exp_d))
    else begin
        value_errs++;
        $display("ERR %s expected %h actual %h", test_name,
                 $sampled(exp_d), $sampled(o_data_out));
    end

    // idle data port never stalls
    d_idle_check: assert property (@(posedge clk) disable iff (!i_rst_n)
        !i_d_mem_en |-> !o_d_fsm_busy)
    else begin
        other_errs++;
        $display("%s: data busy high while the data port is idle", test_name);
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT) begin
            $display("timeout: run hung in %s after %0d cycles", test_name, cycle_cnt);
            $display("ops %0d, value errors %0d, other errors %0d",
                     op_cnt, value_errs, other_errs);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // 32-bit fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        logic        fb;
        int          k;
        v = '0;
        for (k = 0; k < n; k++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[14:0], fb};
        end
        return v;
    endfunction

    task automatic wait_idle(input logic use_i, input logic use_d);
        last_busy = 0;
        @(posedge clk);                                   // first sample after issue
        while ((use_i && o_i_fsm_busy) || (use_d && o_d_fsm_busy)) begin
            last_busy++;
            @(posedge clk);
        end
    endtask

    task automatic fetch(input logic [7:0] addr, input logic must_hit);
        i_instr_addr <= {8'h00, addr};
        exp_i        <= shadow[addr];
        chk_instr    <= 1'b1;
        i_d_mem_en   <= 1'b0;                             // data port quiet
        i_d_wrt_en   <= 1'b0;
        chk_data     <= 1'b0;
        op_cnt++;
        wait_idle(1'b1, 1'b0);
        if (must_hit) begin
            assert (last_busy == 0) else begin
                other_errs++;
                $display("%s: refetch of %h stalled %0d cycles instead of hitting",
                         test_name, addr, last_busy);
            end
        end
    endtask

    task automatic d_read(input logic [7:0] addr);
        i_data_addr <= {8'h00, addr};
        i_d_mem_en  <= 1'b1;
        i_d_wrt_en  <= 1'b0;
        exp_d       <= shadow[addr];
        chk_data    <= 1'b1;
        chk_instr   <= 1'b0;
        op_cnt++;
        wait_idle(1'b0, 1'b1);
    endtask

    task automatic d_write(input logic [7:0] addr, input logic [15:0] data);
        i_data_addr <= {8'h00, addr};
        i_data_in   <= data;
        i_d_mem_en  <= 1'b1;
        i_d_wrt_en  <= 1'b1;
        chk_data    <= 1'b0;
        chk_instr   <= 1'b0;
        shadow[addr] = data;                              // memory holds it after the op
        op_cnt++;
        wait_idle(1'b0, 1'b1);
    endtask

    // fetch miss and load miss raised on the same edge
    task automatic both_miss(input logic [7:0] ia, input logic [7:0] da);
        i_instr_addr <= {8'h00, ia};
        exp_i        <= shadow[ia];
        chk_instr    <= 1'b1;
        i_data_addr  <= {8'h00, da};
        i_d_mem_en   <= 1'b1;
        i_d_wrt_en   <= 1'b0;
        exp_d        <= shadow[da];
        chk_data     <= 1'b1;
        op_cnt += 2;
        wait_idle(1'b1, 1'b1);
    endtask

    task automatic random_mix(input int n);
        logic [15:0] op;
        logic [15:0] a;
        logic [15:0] d;
        int          k;
        for (k = 0; k < n; k++) begin
            op = rand_bits(2);
            case (op[1:0])
                2'd0: begin
                    a = rand_bits(7);                     // fetches stay below 128
                    fetch(a[7:0], 1'b0);
                end
                2'd2: begin
                    a = rand_bits(7);
                    d = rand_bits(16);
                    d_write({1'b1, a[6:0]}, d);           // stores stay at 128 and up
                end
                default: begin
                    a = rand_bits(8);
                    d_read(a[7:0]);
                end
            endcase
        end
    endtask

    initial begin
        clk          = 1'b0;
        i_rst_n      = 1'b0;
        i_instr_addr = '0;                                // first fetch is address 0
        i_data_addr  = '0;
        i_data_in    = '0;
        i_d_wrt_en   = 1'b0;
        i_d_mem_en   = 1'b0;
        lfsr_q       = 32'he6fe;
        value_errs   = 0;
        other_errs   = 0;
        op_cnt       = 0;
        cycle_cnt    = 0;
        last_busy    = 0;
        test_name    = "reset_state";
        for (int k = 0; k < 256; k++) begin
            shadow[k] = 16'(k) ^ MEM_INIT_PATTERN;
        end
        exp_i     = shadow[0];
        chk_instr = 1'b1;
        chk_data  = 1'b0;

        repeat (4) @(posedge clk);
        i_rst_n <= 1'b1;
        @(posedge clk);                                   // first cycle out of reset
        assert (o_i_fsm_busy) else begin
            other_errs++;
            $display("%s: fetch busy low although the first fetch misses", test_name);
        end
        op_cnt++;
        while (o_i_fsm_busy) @(posedge clk);

        test_name <= "instr_miss_hit";
        fetch(8'h12, 1'b0);
        assert (last_busy == MEM_LATENCY + 2) else begin
            value_errs++;
            $display("ERR %s_latency expected %0d actual %0d", test_name,
                     MEM_LATENCY + 2, last_busy);
        end
        fetch(8'h12, 1'b1);

        test_name <= "write_through";
        d_read(8'ha3);
        d_write(8'ha3, 16'hbeef);                         // hit, updated in place
        d_read(8'ha3);
        fetch(8'ha3, 1'b0);                               // icache sees the stored word
        d_write(8'hc7, 16'h1234);                         // miss, no allocate
        d_read(8'hc7);

        test_name <= "conflict_evict";
        for (int k = 0; k < 2; k++) begin
            fetch(8'h25, 1'b0);
            fetch(8'h35, 1'b0);                           // same index, other tag
            d_read(8'h46);
            d_read(8'h56);
        end

        test_name <= "both_miss";
        both_miss(8'h47, 8'h58);

        test_name <= "random_mix";
        random_mix(60);

        i_d_mem_en <= 1'b0;
        i_d_wrt_en <= 1'b0;
        chk_instr  <= 1'b0;
        chk_data   <= 1'b0;
        repeat (3) @(posedge clk);

        $display("ops %0d, value errors %0d, other errors %0d", op_cnt, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
design/mem_pkg.sv
design/icache.sv
design/dcache.sv
design/mem_arbiter.sv
design/mem_model.sv
design/mem_interface.sv
bench/tb_mem_interface.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile with verilator, run, then decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f files.f --top-module tb_mem_interface -o sim \
    && ./obj_dir/sim > sim.log 2>&1 \
    || { echo "build or simulation run failed"; exit 1; }

cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0
